// ==== memsys_pkg.sv ====
`default_nettype none

package memsys_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;                 // byte address, bits 31:2 index words
    typedef logic [31:0] mask_t;                 // set bit = store replaces this bit

    // command between arbiter, access controller and RAM
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t wmask;
    } mem_cmd_t;

    // data side request from the core
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t wmask;
    } data_req_t;

    typedef enum logic [1:0] {
        wait_cmd,                                // idle, both ready levels high
        wait_ready,                              // command held until memory ready
        wait_read                                // read issued, waiting for the word
    } arb_state_t;

    // old bits where mask is 0, new bits where mask is 1
    function automatic word_t merge_word(word_t old_word, word_t new_word, mask_t mask);
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

`default_nettype wire

// ==== mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_array #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       ram_start,
    input  wire memsys_pkg::mem_cmd_t ram_cmd,
    output logic                      ram_ready,
    output memsys_pkg::word_t         ram_rdata,
    output logic                      ram_rvalid
);
    import memsys_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] lat_cnt;                   // cycles left until read data is valid
    logic             take;

    assign idx        = ram_cmd.addr[IDX_W+1:2];
    assign take       = ram_start && ram_ready;
    assign ram_rvalid = (lat_cnt == CNT_W'(1));
    assign ram_ready  = (lat_cnt <= CNT_W'(1));  // back to high in the rvalid cycle

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (take && !ram_cmd.write) begin
            lat_cnt <= CNT_W'(READ_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    always @(posedge clk) begin
        if (take) begin
            if (ram_cmd.write) begin
                mem[idx] <= ram_cmd.wdata;       // whole word, masks resolved upstream
            end else begin
                ram_rdata <= mem[idx];           // held until the next read
            end
        end
    end

    a_index_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (ram_cmd.addr[31:2] < MEM_WORDS));

    // partial stores must have been turned into read-modify-write by now
    a_full_mask_write: assert property (@(posedge clk) disable iff (!rst_n)
        (take && ram_cmd.write) |-> (ram_cmd.wmask == '1));

endmodule

`default_nettype wire

// ==== mem_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl #(
    parameter int READ_LATENCY = 2
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cmd_start,
    input  wire memsys_pkg::mem_cmd_t cmd,
    output logic                      cmd_ready,
    output memsys_pkg::word_t         rsp_data,
    output logic                      rsp_valid,
    output logic                      ram_start,
    output memsys_pkg::mem_cmd_t      ram_cmd,
    input  wire                       ram_ready,
    input  wire memsys_pkg::word_t    ram_rdata,
    input  wire                       ram_rvalid
);
    import memsys_pkg::*;

    typedef enum logic [1:0] {
        ac_idle,
        ac_rmw_read,                             // internal read of the old word
        ac_rmw_write                             // merged word goes back
    } ac_state_t;

    ac_state_t state;
    addr_t     held_addr;
    word_t     held_wdata;                       // store data, then the merged word
    mask_t     held_wmask;
    logic      partial;
    logic      take_rmw;

    assign partial   = cmd.write && (cmd.wmask != '1);
    assign cmd_ready = (state == ac_idle) && ram_ready;
    assign take_rmw  = cmd_start && cmd_ready && partial;

    assign rsp_data  = ram_rdata;
    assign rsp_valid = ram_rvalid && (state == ac_idle);  // internal read stays hidden

    always_comb begin
        ram_start = 1'b0;
        ram_cmd   = cmd;
        case (state)
            ac_idle: begin
                ram_start     = cmd_start && cmd_ready;
                ram_cmd.write = cmd.write && !partial;  // partial store reads first
            end
            ac_rmw_write: begin
                ram_start = ram_ready;
                ram_cmd   = '{write: 1'b1, addr: held_addr, wdata: held_wdata, wmask: '1};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ac_idle;
        end else begin
            case (state)
                ac_idle: begin
                    if (take_rmw) begin
                        state <= ac_rmw_read;
                    end
                end
                ac_rmw_read: begin
                    if (ram_rvalid) begin
                        state <= ac_rmw_write;
                    end
                end
                ac_rmw_write: begin
                    if (ram_ready) begin
                        state <= ac_idle;
                    end
                end
                default: state <= ac_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_rmw) begin
            held_addr  <= cmd.addr;
            held_wdata <= cmd.wdata;
            held_wmask <= cmd.wmask;
        end else if ((state == ac_rmw_read) && ram_rvalid) begin
            held_wdata <= merge_word(ram_rdata, held_wdata, held_wmask);
        end
    end

    a_start_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> cmd_ready);

    // the old word must come back exactly READ_LATENCY cycles after the take
    a_rmw_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        take_rmw |=> ##(READ_LATENCY - 1) ram_rvalid);

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        halt,
    input  wire                        inst_start,
    input  wire memsys_pkg::addr_t     i_addr,
    output logic                       inst_ready,
    output memsys_pkg::word_t          inst,
    output logic                       inst_valid,
    input  wire                        d_start,
    input  wire memsys_pkg::data_req_t d_req,
    output logic                       d_ready,
    output memsys_pkg::word_t          rdata,
    output logic                       rdata_valid,
    output logic                       cmd_start,
    output memsys_pkg::mem_cmd_t       cmd,
    input  wire                        cmd_ready,
    input  wire memsys_pkg::word_t     rsp_data,
    input  wire                        rsp_valid
);
    import memsys_pkg::*;

    arb_state_t state;
    logic       cmd_is_inst;                     // outstanding command is the fetch
    logic       held_d_start;                    // data command waits behind the fetch
    addr_t      held_i_addr;
    data_req_t  held_d;
    logic       rsp_pend;                        // word arrived while halted
    word_t      pend_data;
    word_t      save_i_rdata;
    word_t      save_d_rdata;
    logic       resp_now;
    word_t      resp_word;

    function automatic mem_cmd_t fetch_cmd(addr_t addr);
        mem_cmd_t c;
        c      = '0;
        c.addr = addr;
        return c;
    endfunction

    function automatic mem_cmd_t data_cmd(data_req_t req);
        mem_cmd_t c;
        c.write = req.write;
        c.addr  = req.addr;
        c.wdata = req.wdata;
        c.wmask = req.wmask;
        return c;
    endfunction

    assign resp_now  = (state == wait_read) && (rsp_valid || rsp_pend);
    assign resp_word = rsp_pend ? pend_data : rsp_data;

    assign inst_ready  = (state == wait_cmd);
    assign d_ready     = (state == wait_cmd);
    assign inst_valid  = !halt && resp_now && cmd_is_inst;
    assign rdata_valid = !halt && resp_now && !cmd_is_inst;
    assign inst        = inst_valid ? resp_word : save_i_rdata;
    assign rdata       = rdata_valid ? resp_word : save_d_rdata;

    always_comb begin
        cmd_start = 1'b0;
        cmd       = data_cmd(held_d);
        case (state)
            wait_cmd: begin
                cmd       = inst_start ? fetch_cmd(i_addr) : data_cmd(d_req);  // fetch first
                cmd_start = !halt && cmd_ready && (inst_start || d_start);
            end
            wait_ready: begin
                cmd       = cmd_is_inst ? fetch_cmd(held_i_addr) : data_cmd(held_d);
                cmd_start = !halt && cmd_ready;
            end
            wait_read: begin
                // held data command follows the returning fetch
                cmd_start = !halt && resp_now && cmd_is_inst && held_d_start && cmd_ready;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= wait_cmd;
            cmd_is_inst  <= 1'b0;
            held_d_start <= 1'b0;
            rsp_pend     <= 1'b0;
        end else if (halt) begin
            if ((state == wait_read) && rsp_valid) begin
                rsp_pend <= 1'b1;                // park it until halt drops
            end
        end else begin
            case (state)
                wait_cmd: begin
                    held_d_start <= d_start;
                    if (inst_start) begin
                        cmd_is_inst <= 1'b1;
                        state       <= cmd_ready ? wait_read : wait_ready;
                    end else if (d_start) begin
                        cmd_is_inst <= 1'b0;
                        if (cmd_ready) begin
                            state <= d_req.write ? wait_cmd : wait_read;
                        end else begin
                            state <= wait_ready;
                        end
                    end
                end
                wait_ready: begin
                    if (cmd_ready) begin
                        if (cmd_is_inst || !held_d.write) begin
                            state <= wait_read;
                        end else begin
                            state <= wait_cmd;   // write done at acceptance
                        end
                    end
                end
                wait_read: begin
                    if (resp_now) begin
                        rsp_pend <= 1'b0;
                        if (cmd_is_inst && held_d_start) begin
                            cmd_is_inst <= 1'b0;
                            if (cmd_ready) begin
                                state <= held_d.write ? wait_cmd : wait_read;
                            end else begin
                                state <= wait_ready;
                            end
                        end else begin
                            state <= wait_cmd;
                        end
                    end
                end
                default: state <= wait_cmd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!halt && (state == wait_cmd)) begin
            held_i_addr <= i_addr;
            held_d      <= d_req;
        end
        if (halt && (state == wait_read) && rsp_valid) begin
            pend_data <= rsp_data;
        end
        if (inst_valid) begin
            save_i_rdata <= resp_word;
        end
        if (rdata_valid) begin
            save_d_rdata <= resp_word;
        end
    end

    // callers wait for the ready level, so no start lands during a read
    a_no_start_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        (state == wait_read) |-> !(inst_start || d_start));

    a_rsp_only_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (state == wait_read));

endmodule

`default_nettype wire

// ==== memsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_top #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        halt,            // core has exited
    input  wire                        inst_start,
    input  wire memsys_pkg::addr_t     i_addr,
    output logic                       inst_ready,
    output memsys_pkg::word_t          inst,
    output logic                       inst_valid,
    input  wire                        d_start,
    input  wire memsys_pkg::data_req_t d_req,
    output logic                       d_ready,
    output memsys_pkg::word_t          rdata,
    output logic                       rdata_valid
);
    import memsys_pkg::*;

    logic     cmd_start;
    mem_cmd_t cmd;
    logic     cmd_ready;
    word_t    rsp_data;
    logic     rsp_valid;
    logic     ram_start;
    mem_cmd_t ram_cmd;
    logic     ram_ready;
    word_t    ram_rdata;
    logic     ram_rvalid;

    mem_arbiter mem_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .halt        (halt),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_start     (d_start),
        .d_req       (d_req),
        .d_ready     (d_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .cmd_start   (cmd_start),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .rsp_data    (rsp_data),
        .rsp_valid   (rsp_valid)
    );

    mem_access_ctrl #(
        .READ_LATENCY (READ_LATENCY)
    ) mem_access_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .rsp_data   (rsp_data),
        .rsp_valid  (rsp_valid),
        .ram_start  (ram_start),
        .ram_cmd    (ram_cmd),
        .ram_ready  (ram_ready),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid)
    );

    mem_array #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) mem_array_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ram_start  (ram_start),
        .ram_cmd    (ram_cmd),
        .ram_ready  (ram_ready),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid)
    );

endmodule

`default_nettype wire

// ==== memsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memsys_tb;
    import memsys_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int READ_LATENCY = 2;
    localparam int HALT_CYCLES  = READ_LATENCY + 3;
    localparam int N_ENTRIES    = 18;
    localparam int MAX_CYCLES   = N_ENTRIES * (2 * READ_LATENCY + 8) + 50;

    localparam mask_t M_FULL = 32'hffff_ffff;
    localparam mask_t M_BYTE = 32'h0000_00ff;
    localparam mask_t M_SCAT = 32'h8421_5a0c;    // scattered bits

    typedef enum logic [2:0] {
        k_fetch,
        k_load,
        k_store,
        k_fetch_load,
        k_fetch_store,
        k_halt_pause                             // load held up by halt
    } kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [15:0] i_idx;                      // word index of the fetch
        logic [15:0] d_idx;                      // word index of the load or store
        mask_t       mask;
    } entry_t;

    localparam entry_t TESTS [N_ENTRIES] = '{
        '{k_fetch,       16'd5,  16'd0,  M_FULL},   // never written
        '{k_store,       16'd0,  16'd5,  M_FULL},
        '{k_fetch,       16'd5,  16'd0,  M_FULL},
        '{k_load,        16'd0,  16'd5,  M_FULL},
        '{k_load,        16'd0,  16'd9,  M_FULL},   // never written
        '{k_store,       16'd0,  16'd9,  M_BYTE},
        '{k_load,        16'd0,  16'd9,  M_FULL},
        '{k_store,       16'd0,  16'd5,  M_SCAT},
        '{k_load,        16'd0,  16'd5,  M_FULL},
        '{k_store,       16'd0,  16'd12, M_FULL},
        '{k_fetch_load,  16'd5,  16'd12, M_FULL},
        '{k_fetch_store, 16'd12, 16'd12, M_BYTE},   // fetch sees the old word
        '{k_load,        16'd0,  16'd12, M_FULL},
        '{k_store,       16'd0,  16'd20, M_SCAT},
        '{k_store,       16'd0,  16'd20, M_FULL},
        '{k_halt_pause,  16'd0,  16'd20, M_FULL},   // word returns while halted
        '{k_fetch_store, 16'd7,  16'd7,  M_SCAT},
        '{k_fetch_load,  16'd7,  16'd9,  M_FULL}
    };

    logic      clk;
    logic      rst_n;
    logic      halt;
    logic      inst_start;
    addr_t     i_addr;
    logic      inst_ready;
    word_t     inst;
    logic      inst_valid;
    logic      d_start;
    data_req_t d_req;
    logic      d_ready;
    word_t     rdata;
    logic      rdata_valid;

    word_t       shadow [MEM_WORDS];             // expected RAM contents
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles = 0;

    memsys_top #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) memsys_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .halt        (halt),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_start     (d_start),
        .d_req       (d_req),
        .d_ready     (d_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a response never arrived", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic addr_t word_addr(logic [15:0] idx);
        return {14'd0, idx, 2'b00};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // returns just after a falling edge with both ready levels high
    task automatic wait_idle();
        @(negedge clk);
        while (!(inst_ready === 1'b1 && d_ready === 1'b1)) begin
            @(negedge clk);
        end
    endtask

    task automatic collect(input int n, input logic want_inst, input logic want_data,
                           input word_t exp_inst, input word_t exp_data);
        logic got_inst;
        logic got_data;
        got_inst = !want_inst;
        got_data = !want_data;
        while (!(got_inst && got_data)) begin
            @(posedge clk);
            if (inst_valid) begin
                if (got_inst) begin
                    errors++;
                    $display("entry %0d: fetch response that was not asked for", n);
                end
                check_word($sformatf("entry %0d inst", n), exp_inst, inst);
                got_inst = 1'b1;
            end
            if (rdata_valid) begin
                if (got_data) begin
                    errors++;
                    $display("entry %0d: load response that was not asked for", n);
                end else if (want_inst && !got_inst) begin
                    errors++;
                    $display("entry %0d: load word returned before the fetch word", n);
                end
                check_word($sformatf("entry %0d rdata", n), exp_data, rdata);
                got_data = 1'b1;
            end
        end
        @(posedge clk);                          // arbiter back in wait_cmd
        check_flag($sformatf("entry %0d inst_ready", n), 1'b1, inst_ready);
        check_flag($sformatf("entry %0d d_ready", n), 1'b1, d_ready);
    endtask

    task automatic run_entry(input int n, input entry_t e);
        word_t exp_inst;
        word_t exp_data;
        logic  want_inst;
        logic  want_data;
        logic  is_store;
        want_inst = (e.kind == k_fetch) || (e.kind == k_fetch_load) || (e.kind == k_fetch_store);
        want_data = (e.kind == k_load) || (e.kind == k_fetch_load) || (e.kind == k_halt_pause);
        is_store  = (e.kind == k_store) || (e.kind == k_fetch_store);
        wait_idle();
        exp_inst    = shadow[e.i_idx];           // before this entry's store lands
        i_addr      = word_addr(e.i_idx);
        inst_start  = want_inst;
        d_start     = want_data || is_store;
        d_req       = '0;
        d_req.write = is_store;
        d_req.addr  = word_addr(e.d_idx);
        d_req.wmask = e.mask;
        if (is_store) begin
            rng             = next_random(rng);
            d_req.wdata     = rng;
            shadow[e.d_idx] = (shadow[e.d_idx] & ~e.mask) | (rng & e.mask);
        end
        exp_data = shadow[e.d_idx];
        @(negedge clk);
        inst_start = 1'b0;
        d_start    = 1'b0;
        if (e.kind == k_halt_pause) begin
            halt = 1'b1;
            repeat (HALT_CYCLES) begin
                @(posedge clk);
                check_flag($sformatf("entry %0d halted inst_valid", n), 1'b0, inst_valid);
                check_flag($sformatf("entry %0d halted rdata_valid", n), 1'b0, rdata_valid);
                check_flag($sformatf("entry %0d halted inst_ready", n), 1'b0, inst_ready);
                check_flag($sformatf("entry %0d halted d_ready", n), 1'b0, d_ready);
            end
            @(negedge clk);
            halt = 1'b0;
        end
        if (want_inst || want_data) begin
            collect(n, want_inst, want_data, exp_inst, exp_data);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        halt       = 1'b0;
        inst_start = 1'b0;
        i_addr     = '0;
        d_start    = 1'b0;
        d_req      = '0;
        errors     = 0;
        checks     = 0;
        rng        = 32'hba32e61a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_flag("reset inst_valid", 1'b0, inst_valid);
        check_flag("reset rdata_valid", 1'b0, rdata_valid);
        check_flag("reset inst_ready", 1'b1, inst_ready);
        check_flag("reset d_ready", 1'b1, d_ready);
        for (int n = 0; n < N_ENTRIES; n++) begin
            run_entry(n, TESTS[n]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== memsys.f ====
memsys_pkg.sv
mem_array.sv
mem_access_ctrl.sv
mem_arbiter.sv
memsys_top.sv
memsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = memsys_tb
RTL_TOP   = memsys_top
FILELIST  = memsys.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
